/* cn_node.f */
hw/cn_node_pkg.sv
hw/param_bank.sv
hw/tick_gen.sv
hw/spike_synapse.sv
hw/drive_mixer.sv
hw/lif_neuron.sv
hw/spike_counter.sv
hw/cn_node_top.sv
testbench/cn_node_assertions.sv
testbench/cn_node_tb.sv

/* testbench/cn_node_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_node_tb;

    localparam int NPS    = 4;     // neuron ticks per sim tick
    localparam int HALF   = 2;     // half count used by the tests
    localparam int N_ROWS = 6;

    logic        ep50trig;
    logic        reset_global;
    logic        i_sim_clear;
    logic [15:0] i_trig;
    logic [15:0] i_wire_lo;
    logic [15:0] i_wire_hi;
    logic [3:0]  spk;              // ia, ii, m1a, m1b
    logic        o_sim_tick;
    logic        o_spike;
    logic [31:0] o_drive;
    logic [15:0] o_spike_count;

    // stimulus table, one row per test
    string       row_name  [N_ROWS];
    int          row_bit   [N_ROWS];   // trigger bit, -1 for no load
    logic [31:0] row_word  [N_ROWS];
    logic [3:0]  row_spk   [N_ROWS];
    bit          row_clear [N_ROWS];
    int          row_ticks [N_ROWS];
    longint      row_exp_drive [N_ROWS];   // o_drive at the last tick, -1 when not fixed
    int          row_exp_cnt   [N_ROWS];   // o_spike_count at the last tick, -1 when not fixed

    // reference model state
    logic [31:0] cur [4];
    bit          pend [4];
    logic [31:0] gain, extra_gain, extra_drive;
    logic [31:0] model_drive, drive_pp, mem;
    int          exp_count;
    int          n_checks, n_errors;

    cn_node_top #(.NEURON_PER_SIM (NPS)) cn_node_top_i (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_clear (i_sim_clear),
        .i_trig (i_trig), .i_wire_lo (i_wire_lo), .i_wire_hi (i_wire_hi),
        .i_spike_ia (spk[0]), .i_spike_ii (spk[1]), .i_spike_m1a (spk[2]),
        .i_spike_m1b (spk[3]), .o_sim_tick (o_sim_tick), .o_spike (o_spike),
        .o_drive (o_drive), .o_spike_count (o_spike_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;   // 100 ns period
    end

    task automatic check_value(input string name, input longint expv, input longint actv);
        n_checks++;
        if (expv != actv)
        begin
            n_errors++;
            $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, name, expv, actv);
        end
    endtask

    task automatic wait_tick();
        @(negedge ep50trig);
        while (!o_sim_tick)
            @(negedge ep50trig);   // watchdog bounds this
    endtask

    // model state back to rest, loaded parameters stay
    task automatic reset_model();
        model_drive = 0;
        drive_pp    = 0;
        mem         = 0;
        exp_count   = 0;
        for (int i = 0; i < 4; i++)
        begin
            cur[i]  = 0;
            pend[i] = 0;
        end
    endtask

    // one neuron evaluation per the leaky integrate and fire rule
    function automatic int eval_neuron(input logic [31:0] d);
        logic [32:0] s;
        s = {1'b0, mem} + {1'b0, d};
        if (s >= 33'(30 << 10))
        begin
            mem = '0;
            return 1;
        end
        mem = s[31:0] - (mem >> 4);
        return 0;
    endfunction

    // called at the negedge where o_sim_tick is seen, before the latch edge
    task automatic handle_tick();
        int cnt;
        check_value("o_drive", model_drive, o_drive);
        check_value("o_spike_count", exp_count, o_spike_count);
        cnt = eval_neuron(drive_pp);   // first eval of the window still sees the old drive
        for (int i = 1; i < NPS; i++)
            cnt += eval_neuron(model_drive);
        exp_count   = cnt;
        drive_pp    = model_drive;
        model_drive = cur[0] + cur[1] + extra_gain * (cur[2] + cur[3]) + extra_drive;
        for (int i = 0; i < 4; i++)
        begin
            cur[i]  = cur[i] - (cur[i] >> 3) + (pend[i] ? gain : 32'd0);
            pend[i] = 1'b0;
        end
    endtask

    task automatic set_row(input int r, input string name, input int trig_bit,
                           input logic [31:0] word, input logic [3:0] spikes, input bit clr,
                           input int ticks, input longint exp_drive, input int exp_cnt);
        row_name[r]      = name;
        row_bit[r]       = trig_bit;
        row_word[r]      = word;
        row_spk[r]       = spikes;
        row_clear[r]     = clr;
        row_ticks[r]     = ticks;
        row_exp_drive[r] = exp_drive;
        row_exp_cnt[r]   = exp_cnt;
    endtask

    task automatic fill_table();
        // ia decays 1024, 896, 784; clear keeps the 512 weight and the 40000 drive
        //      row name                trig word   spikes   clr ticks drive  count
        set_row(0, "spindle ia decay", -1,  0,     4'b0001, 0,  5,    784,   0);
        set_row(1, "summed ia ii",      3,  512,   4'b0011, 0,  4,    -1,    0);
        set_row(2, "cortical gain",     13, 3,     4'b0100, 0,  5,    -1,    -1);
        set_row(3, "neuron firing",     8,  40000, 4'b0000, 0,  4,    -1,    4);
        set_row(4, "simulation clear",  -1, 0,     4'b0001, 1,  4,    40448, 4);
        set_row(5, "neuron quiet",      8,  0,     4'b0000, 0,  8,    -1,    0);
    endtask

    // limit from the table length, doubled
    initial
    begin
        longint total;
        #1;
        total = 12;   // reset and tick spacing test
        for (int r = 0; r < N_ROWS; r++)
            total += row_ticks[r] + 1;
        #(total * HALF * NPS * 100 * 2);
        $display("timeout: no sim tick seen in the expected time");
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        int n, errs_before, sp_k;
        void'($urandom(32'h3863c3d6));
        fill_table();
        reset_global = 1'b1;
        i_sim_clear  = 1'b0;
        i_trig       = '0;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        spk          = '0;
        gain         = 1024;   // parameter values after reset
        extra_gain   = 1;
        extra_drive  = 0;
        n_checks     = 0;
        n_errors     = 0;
        reset_model();
        repeat (10) @(negedge ep50trig);
        reset_global = 1'b0;
        @(negedge ep50trig);
        check_value("o_drive", 0, o_drive);
        check_value("o_spike_count", 0, o_spike_count);
        check_value("o_spike", 0, o_spike);
        check_value("o_sim_tick", 0, o_sim_tick);
        i_trig[7] = 1'b1;   // half count load also restarts tick_gen
        i_wire_lo = 16'(HALF);
        @(negedge ep50trig);
        i_trig = '0;
        wait_tick();
        handle_tick();
        repeat (2)
        begin
            n = 0;
            do
            begin
                @(negedge ep50trig);
                n++;
            end
            while (!o_sim_tick);
            check_value("o_sim_tick spacing", HALF * NPS, n);
            handle_tick();
        end
        $display("test reset state: %s", (n_errors == 0) ? "ok" : "errors");

        for (int r = 0; r < N_ROWS; r++)
        begin
            errs_before = n_errors;
            sp_k = 2 + ($urandom % 3);   // spike phase within the period
            for (int k = 0; k < 5; k++)
            begin
                i_trig      = '0;
                i_sim_clear = row_clear[r] && (k == 1);
                spk         = (k == sp_k) ? row_spk[r] : 4'b0000;
                if (k == 0 && row_bit[r] >= 0)
                begin
                    i_trig[row_bit[r]] = 1'b1;
                    {i_wire_hi, i_wire_lo} = row_word[r];
                    case (row_bit[r])
                        3:  gain        = row_word[r];
                        8:  extra_drive = row_word[r];
                        13: extra_gain  = row_word[r];
                        default: ;
                    endcase
                end
                if (row_clear[r] && k == 2)
                begin
                    // clear was sampled one edge ago
                    check_value("o_drive", 0, o_drive);
                    check_value("o_spike_count", 0, o_spike_count);
                    reset_model();
                end
                if (k == sp_k)
                    for (int i = 0; i < 4; i++)
                        if (row_spk[r][i])
                            pend[i] = 1'b1;
                @(negedge ep50trig);
            end
            i_trig      = '0;
            i_sim_clear = 1'b0;
            spk         = '0;
            for (int t = 0; t < row_ticks[r]; t++)
            begin
                wait_tick();
                handle_tick();
            end
            // fixed table values at the last tick of the row
            if (row_exp_drive[r] >= 0)
                check_value("o_drive", row_exp_drive[r], o_drive);
            if (row_exp_cnt[r] >= 0)
                check_value("o_spike_count", row_exp_cnt[r], o_spike_count);
            $display("test %s: %0d errors", row_name[r], n_errors - errs_before);
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/cn_node_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_node_assertions
#(
    parameter int unsigned NEURON_PER_SIM = 128
)
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_tick,      // top level o_sim_tick
    input  logic [cn_node_pkg::DATA_W-1:0]   i_drive,         // top level o_drive
    input  logic [cn_node_pkg::CNT_W-1:0]    i_spike_count    // top level o_spike_count
);

    // sim tick is a single cycle strobe
    sim_tick_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_sim_tick |=> !i_sim_tick)
        else $error("o_sim_tick stayed high for two cycles");

    // at most one spike per neuron tick
    count_bounded: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_spike_count <= cn_node_pkg::CNT_W'(NEURON_PER_SIM))
        else $error("o_spike_count is above the neuron ticks per period");

    drive_zero_after_reset: assert property (@(posedge ep50trig)
        reset_global |=> i_drive == '0)
        else $error("o_drive is not zero after reset");

endmodule

// attach to every top level instance
bind cn_node_top cn_node_assertions #(
    .NEURON_PER_SIM (NEURON_PER_SIM)
) cn_node_assertions_i (
    .ep50trig      (ep50trig),
    .reset_global  (reset_global),
    .i_sim_tick    (o_sim_tick),
    .i_drive       (o_drive),
    .i_spike_count (o_spike_count)
);

`default_nettype wire

/* hw/cn_node_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_node_top
#(
    parameter int unsigned NEURON_PER_SIM = 128   // neuron ticks per sim tick
)
(
    input  logic                             ep50trig,       // system clock
    input  logic                             reset_global,   // async, active high
    input  logic                             i_sim_clear,    // clear sim state, keep params
    input  logic [cn_node_pkg::TRIG_W-1:0]   i_trig,         // parameter load triggers
    input  logic [cn_node_pkg::WIRE_W-1:0]   i_wire_lo,
    input  logic [cn_node_pkg::WIRE_W-1:0]   i_wire_hi,
    input  logic                             i_spike_ia,     // spindle ia afferent
    input  logic                             i_spike_ii,     // spindle ii afferent
    input  logic                             i_spike_m1a,    // cortical extra input 1
    input  logic                             i_spike_m1b,    // cortical extra input 2
    output logic                             o_sim_tick,
    output logic                             o_spike,
    output logic [cn_node_pkg::DATA_W-1:0]   o_drive,
    output logic [cn_node_pkg::CNT_W-1:0]    o_spike_count
);

    logic [cn_node_pkg::DATA_W-1:0] half_cnt;
    logic [cn_node_pkg::DATA_W-1:0] syn_gain;
    logic [cn_node_pkg::DATA_W-1:0] extra_gain;
    logic [cn_node_pkg::DATA_W-1:0] extra_drive;
    logic                           half_cnt_load;   // restarts the tick counters
    logic                           neuron_tick;
    logic [cn_node_pkg::DATA_W-1:0] cur_ia;
    logic [cn_node_pkg::DATA_W-1:0] cur_ii;
    logic [cn_node_pkg::DATA_W-1:0] cur_m1a;
    logic [cn_node_pkg::DATA_W-1:0] cur_m1b;

    assign half_cnt_load = i_trig[cn_node_pkg::TRIG_HALF_CNT];

    param_bank param_bank_i (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_trig        (i_trig),
        .i_wire_lo     (i_wire_lo),
        .i_wire_hi     (i_wire_hi),
        .o_half_cnt    (half_cnt),
        .o_syn_gain    (syn_gain),
        .o_extra_gain  (extra_gain),
        .o_extra_drive (extra_drive)
    );

    tick_gen #(
        .NEURON_PER_SIM (NEURON_PER_SIM)
    ) tick_gen_i (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_half_cnt      (half_cnt),
        .i_half_cnt_load (half_cnt_load),
        .o_neuron_tick   (neuron_tick),
        .o_sim_tick      (o_sim_tick)
    );

    // spindle afferents
    spike_synapse syn_ia_i (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_clear (i_sim_clear),
        .i_spike  (i_spike_ia), .i_sim_tick (o_sim_tick), .i_gain (syn_gain),
        .o_current (cur_ia)
    );

    spike_synapse syn_ii_i (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_clear (i_sim_clear),
        .i_spike  (i_spike_ii), .i_sim_tick (o_sim_tick), .i_gain (syn_gain),
        .o_current (cur_ii)
    );

    // cortical extra inputs, scaled later by extra_gain
    spike_synapse syn_m1a_i (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_clear (i_sim_clear),
        .i_spike  (i_spike_m1a), .i_sim_tick (o_sim_tick), .i_gain (syn_gain),
        .o_current (cur_m1a)
    );

    spike_synapse syn_m1b_i (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_clear (i_sim_clear),
        .i_spike  (i_spike_m1b), .i_sim_tick (o_sim_tick), .i_gain (syn_gain),
        .o_current (cur_m1b)
    );

    drive_mixer drive_mixer_i (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_clear   (i_sim_clear),
        .i_sim_tick    (o_sim_tick),
        .i_ia          (cur_ia),
        .i_ii          (cur_ii),
        .i_m1a         (cur_m1a),
        .i_m1b         (cur_m1b),
        .i_extra_gain  (extra_gain),
        .i_extra_drive (extra_drive),
        .o_drive       (o_drive)
    );

    lif_neuron lif_neuron_i (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_clear   (i_sim_clear),
        .i_neuron_tick (neuron_tick),
        .i_drive       (o_drive),
        .o_spike       (o_spike)
    );

    spike_counter spike_counter_i (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_clear   (i_sim_clear),
        .i_spike       (o_spike),
        .i_sim_tick    (o_sim_tick),
        .o_spike_count (o_spike_count)
    );

endmodule

`default_nettype wire

/* hw/spike_counter.sv */
`default_nettype none
`timescale 1ns/1ps

module spike_counter
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_clear,
    input  logic                             i_spike,        // one-cycle spike pulse
    input  logic                             i_sim_tick,     // end of period
    output logic [cn_node_pkg::CNT_W-1:0]    o_spike_count   // spikes in last period
);

    logic [cn_node_pkg::CNT_W-1:0] run_cnt;   // spikes so far this period
    logic [cn_node_pkg::CNT_W-1:0] cnt_inc;   // running count with this cycle's spike

    assign cnt_inc = run_cnt + cn_node_pkg::CNT_W'(i_spike);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            run_cnt       <= '0;
            o_spike_count <= '0;
        end
        else if (i_sim_clear)
        begin
            run_cnt       <= '0;
            o_spike_count <= '0;
        end
        else if (i_sim_tick)
        begin
            o_spike_count <= cnt_inc;   // includes a spike in the tick cycle
            run_cnt       <= '0;
        end
        else
            run_cnt <= cnt_inc;
    end

endmodule

`default_nettype wire

/* hw/lif_neuron.sv */
`default_nettype none
`timescale 1ns/1ps

module lif_neuron
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_clear,    // membrane back to rest
    input  logic                             i_neuron_tick,  // integration strobe
    input  logic [cn_node_pkg::DATA_W-1:0]   i_drive,        // input current
    output logic                             o_spike         // one cycle after a firing tick
);

    localparam int unsigned SW = cn_node_pkg::DATA_W + 1;   // sum with carry

    logic [cn_node_pkg::DATA_W-1:0] v_mem;      // membrane potential
    logic [cn_node_pkg::DATA_W-1:0] leak;       // loss this tick
    logic [SW-1:0]                  v_sum;      // membrane plus drive, no wrap
    logic                           fire;       // threshold reached

    assign leak  = v_mem >> cn_node_pkg::LEAK_SHIFT;
    assign v_sum = {1'b0, v_mem} + {1'b0, i_drive};
    assign fire  = v_sum >= {1'b0, cn_node_pkg::SPIKE_TH};

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            v_mem   <= '0;
            o_spike <= 1'b0;
        end
        else if (i_sim_clear)
        begin
            v_mem   <= '0;
            o_spike <= 1'b0;
        end
        else if (i_neuron_tick)
        begin
            if (fire)
            begin
                v_mem   <= '0;     // reset after the spike
                o_spike <= 1'b1;
            end
            else
            begin
                // below threshold so v_sum fits in DATA_W
                v_mem   <= v_sum[cn_node_pkg::DATA_W-1:0] - leak;
                o_spike <= 1'b0;
            end
        end
        else
            o_spike <= 1'b0;   // pulse lasts one cycle
    end

endmodule

`default_nettype wire

/* hw/drive_mixer.sv */
`default_nettype none
`timescale 1ns/1ps

module drive_mixer
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_clear,
    input  logic                             i_sim_tick,     // latch strobe
    input  logic [cn_node_pkg::DATA_W-1:0]   i_ia,           // spindle ia current
    input  logic [cn_node_pkg::DATA_W-1:0]   i_ii,           // spindle ii current
    input  logic [cn_node_pkg::DATA_W-1:0]   i_m1a,          // cortical current a
    input  logic [cn_node_pkg::DATA_W-1:0]   i_m1b,          // cortical current b
    input  logic [cn_node_pkg::DATA_W-1:0]   i_extra_gain,   // scale on both m1 paths
    input  logic [cn_node_pkg::DATA_W-1:0]   i_extra_drive,  // constant bias current
    output logic [cn_node_pkg::DATA_W-1:0]   o_drive         // neuron drive, held per period
);

    logic [cn_node_pkg::DATA_W-1:0] spindle;     // ia + ii
    logic [cn_node_pkg::DATA_W-1:0] m1_sum;      // m1a + m1b
    logic [cn_node_pkg::DATA_W-1:0] cortical;    // gain-scaled cortical current
    logic [cn_node_pkg::DATA_W-1:0] drive_nxt;   // full sum, wraps at DATA_W

    assign spindle   = i_ia + i_ii;
    assign m1_sum    = i_m1a + i_m1b;
    assign cortical  = i_extra_gain * m1_sum;   // low word of the product
    assign drive_nxt = spindle + cortical + i_extra_drive;

    // synapse currents here are the values before this tick's update,
    // so a new spike shows on the drive one period after uptake
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_drive <= '0;
        else if (i_sim_clear)
            o_drive <= '0;
        else if (i_sim_tick)
            o_drive <= drive_nxt;   // latched once per sim period
    end

endmodule

`default_nettype wire

/* hw/spike_synapse.sv */
`default_nettype none
`timescale 1ns/1ps

module spike_synapse
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_clear,   // sync return to rest
    input  logic                             i_spike,       // async spike from another board
    input  logic                             i_sim_tick,    // current update strobe
    input  logic [cn_node_pkg::DATA_W-1:0]   i_gain,        // added per captured spike
    output logic [cn_node_pkg::DATA_W-1:0]   o_current      // postsynaptic current
);

    logic                           sync_q1;   // first synchronizer stage
    logic                           sync_q2;   // second stage, safe to use
    logic                           sync_d;    // delayed copy for edge detect
    logic                           rise;      // rising edge of the spike
    logic                           pending;   // spike waiting for next sim tick
    logic [cn_node_pkg::DATA_W-1:0] decayed;   // current after one step of decay

    assign rise    = sync_q2 & ~sync_d;
    assign decayed = o_current - (o_current >> cn_node_pkg::DECAY_SHIFT);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            sync_d    <= 1'b0;
            pending   <= 1'b0;
            o_current <= '0;
        end
        else if (i_sim_clear)
        begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            sync_d    <= 1'b0;
            pending   <= 1'b0;
            o_current <= '0;
        end
        else
        begin
            sync_q1 <= i_spike;
            sync_q2 <= sync_q1;
            sync_d  <= sync_q2;
            if (i_sim_tick)
            begin
                // exponential decay, plus one weight if a spike arrived
                o_current <= decayed + (pending ? i_gain : '0);
                pending   <= rise;   // an edge in this cycle waits for the next tick
            end
            else if (rise)
                pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/tick_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tick_gen
#(
    parameter int unsigned NEURON_PER_SIM = 128   // neuron ticks per sim tick
)
(
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic [cn_node_pkg::DATA_W-1:0]   i_half_cnt,       // cycles per neuron tick
    input  logic                             i_half_cnt_load,  // restart both counters
    output logic                             o_neuron_tick,    // one cycle every half count
    output logic                             o_sim_tick        // one cycle per sim period
);

    localparam int unsigned NW = $clog2(NEURON_PER_SIM + 1);

    logic [cn_node_pkg::DATA_W-1:0] cyc_cnt;   // cycles within one neuron period
    logic [cn_node_pkg::DATA_W-1:0] half_eff;  // zero treated as one
    logic [cn_node_pkg::DATA_W-1:0] cyc_last;  // last count before wrap
    logic [NW-1:0]                  n_cnt;     // neuron ticks within one sim period

    assign half_eff = (i_half_cnt == '0) ? cn_node_pkg::DATA_W'(1) : i_half_cnt;
    assign cyc_last = half_eff - cn_node_pkg::DATA_W'(1);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            cyc_cnt       <= '0;
            n_cnt         <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
        else if (i_half_cnt_load)
        begin
            cyc_cnt       <= '0;   // new half count seen next cycle
            n_cnt         <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
        else if (cyc_cnt >= cyc_last)
        begin
            cyc_cnt       <= '0;
            o_neuron_tick <= 1'b1;
            if (n_cnt == NW'(NEURON_PER_SIM - 1))
            begin
                n_cnt      <= '0;
                o_sim_tick <= 1'b1;   // coincides with the last neuron tick
            end
            else
            begin
                n_cnt      <= n_cnt + NW'(1);
                o_sim_tick <= 1'b0;
            end
        end
        else
        begin
            cyc_cnt       <= cyc_cnt + cn_node_pkg::DATA_W'(1);
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/param_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module param_bank
(
    input  logic                             ep50trig,       // system clock
    input  logic                             reset_global,   // async, active high
    input  logic [cn_node_pkg::TRIG_W-1:0]   i_trig,         // one bit per parameter
    input  logic [cn_node_pkg::WIRE_W-1:0]   i_wire_lo,      // low half of the word
    input  logic [cn_node_pkg::WIRE_W-1:0]   i_wire_hi,      // high half of the word
    output logic [cn_node_pkg::DATA_W-1:0]   o_half_cnt,     // tick generator half count
    output logic [cn_node_pkg::DATA_W-1:0]   o_syn_gain,     // weight of every synapse
    output logic [cn_node_pkg::DATA_W-1:0]   o_extra_gain,   // cortical current gain
    output logic [cn_node_pkg::DATA_W-1:0]   o_extra_drive   // direct drive to the neuron
);

    logic [cn_node_pkg::DATA_W-1:0] wire_word;  // joined host word

    assign wire_word = {i_wire_hi, i_wire_lo};

    // synaptic weight
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_syn_gain <= cn_node_pkg::RST_SYN_GAIN;
        else if (i_trig[cn_node_pkg::TRIG_SYN_GAIN])
            o_syn_gain <= wire_word;
    end

    // clock divider half count
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_half_cnt <= cn_node_pkg::RST_HALF_CNT;
        else if (i_trig[cn_node_pkg::TRIG_HALF_CNT])
            o_half_cnt <= wire_word;   // tick_gen restarts on the same trigger
    end

    // extra cortical drive
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_extra_drive <= cn_node_pkg::RST_EXTRA_DRIVE;
        else if (i_trig[cn_node_pkg::TRIG_EXTRA_DRIVE])
            o_extra_drive <= wire_word;
    end

    // gain on the two m1 synapses
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_extra_gain <= cn_node_pkg::RST_EXTRA_GAIN;
        else if (i_trig[cn_node_pkg::TRIG_EXTRA_GAIN])
            o_extra_gain <= wire_word;
    end

    // several bits high together all take the same word

endmodule

`default_nettype wire

/* hw/cn_node_pkg.sv */
`default_nettype none

package cn_node_pkg;

    // datapath widths
    localparam int unsigned DATA_W = 32;        // params, currents, drive, membrane
    localparam int unsigned WIRE_W = 16;        // one half of a parameter word
    localparam int unsigned TRIG_W = 16;        // trigger vector from host
    localparam int unsigned CNT_W  = 16;        // spikes per simulation period

    // trigger bit that loads each parameter
    localparam int unsigned TRIG_SYN_GAIN    = 3;
    localparam int unsigned TRIG_HALF_CNT    = 7;
    localparam int unsigned TRIG_EXTRA_DRIVE = 8;
    localparam int unsigned TRIG_EXTRA_GAIN  = 13;

    // parameter values after reset
    localparam logic [DATA_W-1:0] RST_SYN_GAIN    = DATA_W'(1024);  // unit weight in q10
    localparam logic [DATA_W-1:0] RST_HALF_CNT    = DATA_W'(381);   // real time speed
    localparam logic [DATA_W-1:0] RST_EXTRA_GAIN  = DATA_W'(1);
    localparam logic [DATA_W-1:0] RST_EXTRA_DRIVE = DATA_W'(0);

    // fixed threshold, 30 mv scaled by 2^10
    localparam logic [DATA_W-1:0] SPIKE_TH = DATA_W'(30 << 10);

    // decay per simulation tick is i - (i >> DECAY_SHIFT)
    localparam int unsigned DECAY_SHIFT = 3;

    // membrane leak per neuron tick is v >> LEAK_SHIFT
    localparam int unsigned LEAK_SHIFT = 4;

endpackage

`default_nettype wire
